// File: tb.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/fetchStage.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memStage.sv
rtl/mipsCore.sv
tests/mipsCore_sva.sv
tests/mipsCore_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mipsCore_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/mipsCore_tb.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mipsCore_tb;

    localparam int MEM_WORDS = 64;

    // R-type kinds first for the model's destination select
    typedef enum logic [3:0] {
        K_ADDU, K_SUBU, K_AND, K_OR, K_SLT, K_ADDIU, K_LUI, K_LW, K_SW, K_BEQ, K_BNE
    } kind_t;

    typedef struct packed {
        mips_pkg::word_t instr;
        kind_t           kind;
    } row_t;

    logic               clk_i = 1'b0;
    logic               rstN_i;
    mips_pkg::word_t    instAddr_o;
    mips_pkg::word_t    instr_i;
    logic               memEn_o;
    logic [3:0]         memWen_o;
    mips_pkg::word_t    memAddr_o;
    mips_pkg::word_t    memWdata_o;
    mips_pkg::word_t    memRdata_i;
    mips_pkg::debugWb_t debugWb_o;

    mips_pkg::word_t    imem [0:MEM_WORDS-1];
    mips_pkg::word_t    dmem [0:MEM_WORDS-1];
    mips_pkg::word_t    refMem [0:MEM_WORDS-1];  // model's copy of data memory
    mips_pkg::word_t    imemOffset;
    row_t               progQ [$];
    mips_pkg::debugWb_t expWr [$];
    mips_pkg::word_t    expStAddr [$];
    mips_pkg::word_t    expStData [$];
    logic [15:0]        lfsr;
    int                 valueErrors = 0;
    int                 otherErrors = 0;

    always #4 clk_i = ~clk_i;

    assign imemOffset = instAddr_o - `MIPS_RESET_PC;
    assign instr_i    = (imemOffset[31:8] == '0) ? imem[imemOffset[7:2]] : '0;  // zero is a no-op
    assign memRdata_i = dmem[memAddr_o[7:2]];

    mipsCore UUT (
        .clk_i      (clk_i),
        .rstN_i     (rstN_i),
        .instAddr_o (instAddr_o),
        .instr_i    (instr_i),
        .memEn_o    (memEn_o),
        .memWen_o   (memWen_o),
        .memAddr_o  (memAddr_o),
        .memWdata_o (memWdata_o),
        .memRdata_i (memRdata_i),
        .debugWb_o  (debugWb_o)
    );

    function automatic logic [15:0] galoisStep(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic drawBits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[14:0], lfsr[0]};
            lfsr = galoisStep(lfsr);
        end
    endtask

    function automatic mips_pkg::word_t fillWord(input mips_pkg::word_t addr);
        return 32'h5EED_0000 ^ {addr[15:0], addr[31:16]} ^ ~addr;
    endfunction

    function automatic mips_pkg::word_t rType(input logic [5:0] fn, input mips_pkg::regNum_t rd,
                                              input mips_pkg::regNum_t rs,
                                              input mips_pkg::regNum_t rt);
        return {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mips_pkg::word_t iType(input logic [5:0] op, input mips_pkg::regNum_t rt,
                                              input mips_pkg::regNum_t rs,
                                              input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addRow(input mips_pkg::word_t instr, input kind_t kind);
        row_t row;
        row.instr = instr;
        row.kind  = kind;
        progQ.push_back(row);
    endtask

    task automatic buildProgram();
        logic [15:0] immA;
        logic [15:0] immB;
        logic [15:0] immC;
        drawBits(16, immA);
        drawBits(16, immB);
        drawBits(12, immC);
        addRow(iType(`MIPS_OP_ADDIU, 5'd1, 5'd0, immA), K_ADDIU);
        addRow(iType(`MIPS_OP_ADDIU, 5'd2, 5'd0, immB), K_ADDIU);
        addRow(rType(`MIPS_FN_ADDU, 5'd3, 5'd1, 5'd2), K_ADDU);  // r1 from wb and r2 from mem
        addRow(rType(`MIPS_FN_SUBU, 5'd4, 5'd3, 5'd1), K_SUBU);
        addRow(rType(`MIPS_FN_AND, 5'd5, 5'd4, 5'd3), K_AND);
        addRow(rType(`MIPS_FN_OR, 5'd6, 5'd5, 5'd2), K_OR);
        addRow(rType(`MIPS_FN_SLT, 5'd7, 5'd6, 5'd4), K_SLT);
        addRow(iType(`MIPS_OP_LUI, 5'd8, 5'd0, 16'h8001), K_LUI);
        addRow(rType(`MIPS_FN_SLT, 5'd9, 5'd8, 5'd6), K_SLT);  // negative operand
        addRow(iType(`MIPS_OP_ADDIU, 5'd10, 5'd8, immC), K_ADDIU);
        addRow(rType(`MIPS_FN_ADDU, 5'd0, 5'd1, 5'd2), K_ADDU);  // r0 target so no write
        addRow(rType(`MIPS_FN_OR, 5'd11, 5'd0, 5'd10), K_OR);
        addRow(iType(`MIPS_OP_ADDIU, 5'd12, 5'd0, 16'h0040), K_ADDIU);
        addRow(iType(`MIPS_OP_SW, 5'd3, 5'd12, 16'h0004), K_SW);
        addRow(iType(`MIPS_OP_LW, 5'd13, 5'd12, 16'h0004), K_LW);
        addRow(rType(`MIPS_FN_ADDU, 5'd14, 5'd13, 5'd1), K_ADDU);  // load used right away
        addRow(iType(`MIPS_OP_LW, 5'd15, 5'd12, 16'h0008), K_LW);
        addRow(iType(`MIPS_OP_BEQ, 5'd1, 5'd1, 16'h0002), K_BEQ);
        addRow(iType(`MIPS_OP_ADDIU, 5'd16, 5'd0, 16'h0001), K_ADDIU);  // delay slot
        addRow(iType(`MIPS_OP_ADDIU, 5'd17, 5'd0, 16'h0002), K_ADDIU);
        addRow(iType(`MIPS_OP_BNE, 5'd2, 5'd1, 16'h0002), K_BNE);
        addRow(iType(`MIPS_OP_SW, 5'd16, 5'd12, 16'h0000), K_SW);
        addRow(iType(`MIPS_OP_SW, 5'd1, 5'd12, 16'h000C), K_SW);
        addRow(iType(`MIPS_OP_BEQ, 5'd2, 5'd1, 16'h0001), K_BEQ);
        addRow(iType(`MIPS_OP_ADDIU, 5'd19, 5'd16, 16'h0005), K_ADDIU);
        addRow(iType(`MIPS_OP_ADDIU, 5'd20, 5'd19, 16'h0006), K_ADDIU);
        addRow(iType(`MIPS_OP_BNE, 5'd0, 5'd0, 16'h0001), K_BNE);
        addRow(iType(`MIPS_OP_SW, 5'd20, 5'd12, 16'h000C), K_SW);
    endtask

    // architectural run of the table with one delay slot per branch
    task automatic runModel();
        mips_pkg::word_t    regs [0:31];
        mips_pkg::word_t    instr;
        mips_pkg::word_t    a;
        mips_pkg::word_t    b;
        mips_pkg::word_t    imm;
        mips_pkg::word_t    res;
        mips_pkg::word_t    addr;
        mips_pkg::regNum_t  dst;
        mips_pkg::debugWb_t rec;
        logic               taken;
        logic               writes;
        int                 idx;
        int                 nextIdx;
        int                 newNext;
        int                 steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        idx     = 0;
        nextIdx = 1;
        steps   = 0;
        while (idx < progQ.size() && steps < 4 * progQ.size()) begin
            instr  = progQ[idx].instr;
            a      = regs[instr[25:21]];
            b      = regs[instr[20:16]];
            imm    = {{16{instr[15]}}, instr[15:0]};
            dst    = (progQ[idx].kind <= K_SLT) ? instr[15:11] : instr[20:16];
            writes = !(progQ[idx].kind inside {K_SW, K_BEQ, K_BNE});
            taken  = 1'b0;
            res    = '0;
            addr   = a + imm;
            case (progQ[idx].kind)
                K_ADDU:  res = a + b;
                K_SUBU:  res = a - b;
                K_AND:   res = a & b;
                K_OR:    res = a | b;
                K_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_ADDIU: res = a + imm;
                K_LUI:   res = {instr[15:0], 16'h0000};
                K_LW:    res = refMem[addr[7:2]];
                K_SW: begin
                    expStAddr.push_back(addr);
                    expStData.push_back(b);
                    refMem[addr[7:2]] = b;
                end
                K_BEQ:   taken = (a == b);
                K_BNE:   taken = (a != b);
                default: writes = 1'b0;
            endcase
            if (writes && dst != '0) begin
                regs[dst] = res;
                rec.pc    = `MIPS_RESET_PC + idx * 4;
                rec.wen   = 4'hF;
                rec.wnum  = dst;
                rec.wdata = res;
                expWr.push_back(rec);
            end
            newNext = taken ? (idx + 1 + int'(imm)) : (nextIdx + 1);  // target skips past slot
            idx     = nextIdx;
            nextIdx = newNext;
            steps++;
        end
    endtask

    task automatic checkWrite(input mips_pkg::debugWb_t exp, input mips_pkg::debugWb_t got);
        if (got !== exp) begin
            valueErrors++;
            $display("ERROR debugWb_o: expected pc %h wnum %h wdata %h, got pc %h wnum %h wdata %h",
                     exp.pc, exp.wnum, exp.wdata, got.pc, got.wnum, got.wdata);
        end
    endtask

    task automatic checkStore(input mips_pkg::word_t expAddr, input mips_pkg::word_t expData,
                              input mips_pkg::word_t gotAddr, input mips_pkg::word_t gotData);
        if (gotAddr !== expAddr || gotData !== expData) begin
            valueErrors++;
            $display("ERROR memAddr_o/memWdata_o: expected %h/%h, got %h/%h",
                     expAddr, expData, gotAddr, gotData);
        end
    endtask

    task automatic checkEnable(input string name, input logic [3:0] exp, input logic [3:0] got);
        if (got !== exp) begin
            valueErrors++;
            $display("ERROR %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic checkWord(input string name, input mips_pkg::word_t exp,
                             input mips_pkg::word_t got);
        if (got !== exp) begin
            valueErrors++;
            $display("ERROR %s: expected %h, got %h", name, exp, got);
        end
    endtask

    initial begin
        mips_pkg::word_t endPc;
        int              cycles;
        int              limit;
        logic            done;
        rstN_i = 1'b0;
        lfsr   = 16'd40627;
        buildProgram();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i]   = (i < progQ.size()) ? progQ[i].instr : '0;
            dmem[i]   = fillWord(i * 4);
            refMem[i] = fillWord(i * 4);
        end
        runModel();
        endPc  = `MIPS_RESET_PC + progQ.size() * 4;
        limit  = 2 * progQ.size() + 50;
        cycles = 0;
        done   = 1'b0;

        // last pass is the cycle right after release
        for (int i = 0; i < 8; i++) begin
            @(posedge clk_i);
            if (i == 7) begin
                rstN_i <= 1'b1;
            end
            @(negedge clk_i);
            checkEnable("debugWb_o.wen", 4'h0, debugWb_o.wen);
            checkEnable("memEn_o", 4'h0, {3'b000, memEn_o});
            checkEnable("memWen_o", 4'h0, memWen_o);
        end
        checkWord("instAddr_o", `MIPS_RESET_PC, instAddr_o);

        while (!done && cycles < limit) begin
            @(negedge clk_i);
            cycles++;
            if (debugWb_o.wen != 4'h0) begin
                if (expWr.size() == 0) begin
                    otherErrors++;
                    $display("Unexpected register write from pc %h", debugWb_o.pc);
                end else begin
                    checkWrite(expWr.pop_front(), debugWb_o);
                end
            end
            if (memEn_o && memWen_o != 4'h0) begin
                checkEnable("memWen_o", 4'hF, memWen_o);
                if (expStAddr.size() == 0) begin
                    otherErrors++;
                    $display("Unexpected store to address %h", memAddr_o);
                end else begin
                    checkStore(expStAddr.pop_front(), expStData.pop_front(), memAddr_o,
                               memWdata_o);
                end
                dmem[memAddr_o[7:2]] = memWdata_o;
            end
            done = ((debugWb_o.pc >= endPc) === 1'b1);  // retired past the last row
        end

        if (!done) begin
            otherErrors++;
            $display("Timeout: program did not retire within %0d cycles", limit);
        end
        if (expWr.size() != 0 || expStAddr.size() != 0) begin
            otherErrors++;
            $display("%0d register writes and %0d stores never appeared",
                     expWr.size(), expStAddr.size());
        end
        $display("Checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tests/mipsCore_sva.sv
`timescale 1ns/1ps

module mipsCore_sva (
    input logic               clk_i,
    input logic               rstN_i,
    input mips_pkg::word_t    instAddr_o,
    input logic               memEn_o,
    input logic [3:0]         memWen_o,
    input mips_pkg::word_t    memAddr_o,
    input mips_pkg::debugWb_t debugWb_o
);

    noZeroRegWrite: assert property (@(posedge clk_i) disable iff (!rstN_i)
        (debugWb_o.wen != 4'h0) |-> (debugWb_o.wnum != '0))
        else $error("debug write names register 0");

    wenNeedsEn: assert property (@(posedge clk_i) disable iff (!rstN_i)
        (memWen_o != 4'h0) |-> memEn_o)
        else $error("byte enables set while the data port is idle");

    dataAligned: assert property (@(posedge clk_i) disable iff (!rstN_i)
        memEn_o |-> (memAddr_o[1:0] == 2'b00))
        else $error("data address %h not word aligned", memAddr_o);

    fetchAligned: assert property (@(posedge clk_i) disable iff (!rstN_i)
        instAddr_o[1:0] == 2'b00)
        else $error("fetch address %h not word aligned", instAddr_o);

endmodule

bind mipsCore mipsCore_sva uSva (
    .clk_i      (clk_i),
    .rstN_i     (rstN_i),
    .instAddr_o (instAddr_o),
    .memEn_o    (memEn_o),
    .memWen_o   (memWen_o),
    .memAddr_o  (memAddr_o),
    .debugWb_o  (debugWb_o)
);

// File: rtl/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
    input  logic               clk_i,
    input  logic               rstN_i,
    output mips_pkg::word_t    instAddr_o,
    input  mips_pkg::word_t    instr_i,
    output logic               memEn_o,
    output logic [3:0]         memWen_o,
    output mips_pkg::word_t    memAddr_o,
    output mips_pkg::word_t    memWdata_o,
    input  mips_pkg::word_t    memRdata_i,
    output mips_pkg::debugWb_t debugWb_o
);

    mips_pkg::redirect_t redirect;
    mips_pkg::word_t     fetchPc;
    mips_pkg::word_t     fetchInstr;
    logic                fetchValid;
    mips_pkg::regNum_t   rsNum;
    mips_pkg::regNum_t   rtNum;
    mips_pkg::word_t     rsData;
    mips_pkg::word_t     rtData;
    mips_pkg::idEx_t     idEx;
    mips_pkg::exMem_t    exMem;
    mips_pkg::word_t     memResult;
    mips_pkg::memWb_t    memWb;

    fetchStage uFetch (
        .clk_i        (clk_i),
        .rstN_i       (rstN_i),
        .redirect_i   (redirect),
        .instr_i      (instr_i),
        .instAddr_o   (instAddr_o),
        .fetchPc_o    (fetchPc),
        .fetchInstr_o (fetchInstr),
        .fetchValid_o (fetchValid)
    );

    regFile uRegFile (
        .clk_i    (clk_i),
        .rstN_i   (rstN_i),
        .rs_i     (rsNum),
        .rt_i     (rtNum),
        .wb_i     (memWb),
        .rsData_o (rsData),
        .rtData_o (rtData)
    );

    decodeStage uDecode (
        .clk_i        (clk_i),
        .rstN_i       (rstN_i),
        .fetchPc_i    (fetchPc),
        .fetchInstr_i (fetchInstr),
        .fetchValid_i (fetchValid),
        .rsData_i     (rsData),
        .rtData_i     (rtData),
        .rs_o         (rsNum),
        .rt_o         (rtNum),
        .idEx_o       (idEx)
    );

    executeStage uExecute (
        .clk_i       (clk_i),
        .rstN_i      (rstN_i),
        .idEx_i      (idEx),
        .exMem_i     (exMem),
        .memResult_i (memResult),
        .memWb_i     (memWb),
        .redirect_o  (redirect),
        .exMem_o     (exMem)
    );

    memStage uMem (
        .clk_i       (clk_i),
        .rstN_i      (rstN_i),
        .exMem_i     (exMem),
        .memRdata_i  (memRdata_i),
        .memEn_o     (memEn_o),
        .memWen_o    (memWen_o),
        .memAddr_o   (memAddr_o),
        .memWdata_o  (memWdata_o),
        .memResult_o (memResult),
        .memWb_o     (memWb)
    );

    // debug record of the instruction retiring this cycle
    assign debugWb_o.pc    = memWb.pc;
    assign debugWb_o.wen   = {4{memWb.valid && memWb.regWrite}};
    assign debugWb_o.wnum  = memWb.dest;
    assign debugWb_o.wdata = memWb.result;

endmodule

// File: rtl/memStage.sv
`timescale 1ns/1ps

module memStage (
    input  logic             clk_i,
    input  logic             rstN_i,
    input  mips_pkg::exMem_t exMem_i,
    input  mips_pkg::word_t  memRdata_i,
    output logic             memEn_o,
    output logic [3:0]       memWen_o,
    output mips_pkg::word_t  memAddr_o,
    output mips_pkg::word_t  memWdata_o,
    output mips_pkg::word_t  memResult_o,
    output mips_pkg::memWb_t memWb_o
);

    logic isStore;

    assign isStore     = exMem_i.valid && exMem_i.ctrl.memWrite;
    assign memEn_o     = exMem_i.valid && (exMem_i.ctrl.memRead || exMem_i.ctrl.memWrite);
    assign memWen_o    = {4{isStore}};  // word stores only
    assign memAddr_o   = exMem_i.aluResult;
    assign memWdata_o  = exMem_i.storeData;
    assign memResult_o = exMem_i.ctrl.memRead ? memRdata_i : exMem_i.aluResult;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            memWb_o.valid    <= 1'b0;
            memWb_o.regWrite <= 1'b0;
        end else begin
            memWb_o.valid    <= exMem_i.valid;
            memWb_o.regWrite <= exMem_i.valid && exMem_i.ctrl.regWrite;
        end
        memWb_o.pc     <= exMem_i.pc;
        memWb_o.dest   <= exMem_i.dest;
        memWb_o.result <= memResult_o;
    end

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic                clk_i,
    input  logic                rstN_i,
    input  mips_pkg::idEx_t     idEx_i,
    input  mips_pkg::exMem_t    exMem_i,
    input  mips_pkg::word_t     memResult_i,
    input  mips_pkg::memWb_t    memWb_i,
    output mips_pkg::redirect_t redirect_o,
    output mips_pkg::exMem_t    exMem_o
);

    mips_pkg::fwdSrc_t rsSel;
    mips_pkg::fwdSrc_t rtSel;
    mips_pkg::word_t   rsVal;
    mips_pkg::word_t   rtVal;
    mips_pkg::word_t   opB;
    mips_pkg::word_t   aluResult;
    logic              equal;
    mips_pkg::exMem_t  exMemNext;

    // memory stage wins over write-back, r0 never forwards
    function automatic mips_pkg::fwdSrc_t fwdSel(input mips_pkg::regNum_t src);
        if (src != '0 && exMem_i.valid && exMem_i.ctrl.regWrite && exMem_i.dest == src)
            return mips_pkg::FWD_MEM;
        if (src != '0 && memWb_i.valid && memWb_i.regWrite && memWb_i.dest == src)
            return mips_pkg::FWD_WB;
        return mips_pkg::FWD_REG;
    endfunction

    function automatic mips_pkg::word_t fwdMux(input mips_pkg::fwdSrc_t sel,
                                               input mips_pkg::word_t regVal);
        case (sel)
            mips_pkg::FWD_MEM: return memResult_i;
            mips_pkg::FWD_WB:  return memWb_i.result;
            default:           return regVal;
        endcase
    endfunction

    assign rsSel = fwdSel(idEx_i.rs);
    assign rtSel = fwdSel(idEx_i.rt);
    assign rsVal = fwdMux(rsSel, idEx_i.rsVal);
    assign rtVal = fwdMux(rtSel, idEx_i.rtVal);
    assign opB   = idEx_i.ctrl.aluSrcImm ? idEx_i.imm : rtVal;

    always_comb begin
        case (idEx_i.ctrl.aluOp)
            mips_pkg::ALU_SUB: aluResult = rsVal - opB;
            mips_pkg::ALU_AND: aluResult = rsVal & opB;
            mips_pkg::ALU_OR:  aluResult = rsVal | opB;
            mips_pkg::ALU_SLT: aluResult = {31'd0, $signed(rsVal) < $signed(opB)};
            mips_pkg::ALU_LUI: aluResult = opB;  // immediate already shifted up
            default:           aluResult = rsVal + opB;
        endcase
    end

    assign equal = (rsVal == rtVal);
    assign redirect_o.taken = idEx_i.valid &&
        ((idEx_i.ctrl.branchKind == mips_pkg::BR_EQ &&  equal) ||
         (idEx_i.ctrl.branchKind == mips_pkg::BR_NE && !equal));
    assign redirect_o.target = idEx_i.brTarget;

    assign exMemNext.valid     = idEx_i.valid;
    assign exMemNext.pc        = idEx_i.pc;
    assign exMemNext.ctrl      = idEx_i.ctrl;
    assign exMemNext.dest      = idEx_i.dest;
    assign exMemNext.aluResult = aluResult;
    assign exMemNext.storeData = rtVal;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            exMem_o.valid <= 1'b0;
            exMem_o.ctrl  <= '0;
        end else begin
            exMem_o <= exMemNext;
        end
    end

endmodule

// File: rtl/decodeStage.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module decodeStage (
    input  logic              clk_i,
    input  logic              rstN_i,
    input  mips_pkg::word_t   fetchPc_i,
    input  mips_pkg::word_t   fetchInstr_i,
    input  logic              fetchValid_i,
    input  mips_pkg::word_t   rsData_i,
    input  mips_pkg::word_t   rtData_i,
    output mips_pkg::regNum_t rs_o,
    output mips_pkg::regNum_t rt_o,
    output mips_pkg::idEx_t   idEx_o
);

    logic [5:0]        opcode;
    logic [5:0]        funct;
    mips_pkg::regNum_t rd;
    mips_pkg::word_t   immSext;
    mips_pkg::ctrl_t   ctrl;
    logic              isRtype;
    mips_pkg::idEx_t   idExNext;

    assign opcode  = fetchInstr_i[31:26];
    assign funct   = fetchInstr_i[5:0];
    assign rs_o    = fetchInstr_i[25:21];
    assign rt_o    = fetchInstr_i[20:16];
    assign rd      = fetchInstr_i[15:11];
    assign immSext = {{16{fetchInstr_i[15]}}, fetchInstr_i[15:0]};
    assign isRtype = (opcode == `MIPS_OP_RTYPE);

    always_comb begin
        ctrl = '0;  // anything unknown is a no-op
        case (opcode)
            `MIPS_OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                case (funct)
                    `MIPS_FN_ADDU: ctrl.aluOp = mips_pkg::ALU_ADD;
                    `MIPS_FN_SUBU: ctrl.aluOp = mips_pkg::ALU_SUB;
                    `MIPS_FN_AND:  ctrl.aluOp = mips_pkg::ALU_AND;
                    `MIPS_FN_OR:   ctrl.aluOp = mips_pkg::ALU_OR;
                    `MIPS_FN_SLT:  ctrl.aluOp = mips_pkg::ALU_SLT;
                    default:       ctrl.regWrite = 1'b0;
                endcase
            end
            `MIPS_OP_ADDIU: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            `MIPS_OP_LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = mips_pkg::ALU_LUI;
            end
            `MIPS_OP_LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            `MIPS_OP_SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            `MIPS_OP_BEQ: ctrl.branchKind = mips_pkg::BR_EQ;
            `MIPS_OP_BNE: ctrl.branchKind = mips_pkg::BR_NE;
            default: ;
        endcase

        idExNext.valid = fetchValid_i;
        idExNext.pc    = fetchPc_i;
        idExNext.rs    = rs_o;
        idExNext.rt    = rt_o;
        idExNext.dest  = isRtype ? rd : rt_o;
        idExNext.rsVal = rsData_i;
        idExNext.rtVal = rtData_i;
        idExNext.imm   = (opcode == `MIPS_OP_LUI) ? {fetchInstr_i[15:0], 16'h0000} : immSext;
        idExNext.brTarget = fetchPc_i + 32'd4 + {immSext[29:0], 2'b00};
        if (idExNext.dest == '0) begin
            ctrl.regWrite = 1'b0;  // r0 writes are dropped here
        end
        idExNext.ctrl = fetchValid_i ? ctrl : '0;  // bubbles carry no control
    end

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            idEx_o.valid <= 1'b0;
            idEx_o.ctrl  <= '0;
        end else begin
            idEx_o <= idExNext;
        end
    end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module regFile (
    input  logic              clk_i,
    input  logic              rstN_i,
    input  mips_pkg::regNum_t rs_i,
    input  mips_pkg::regNum_t rt_i,
    input  mips_pkg::memWb_t  wb_i,
    output mips_pkg::word_t   rsData_o,
    output mips_pkg::word_t   rtData_o
);

    mips_pkg::word_t regs [1:`MIPS_REG_COUNT-1];  // r0 has no storage
    logic            wrEn;

    assign wrEn = rstN_i && wb_i.valid && wb_i.regWrite && (wb_i.dest != '0);

    always_ff @(posedge clk_i) begin
        if (wrEn) begin
            regs[wb_i.dest] <= wb_i.result;
        end
    end

    // write-through so decode sees a result retiring this cycle
    assign rsData_o = (rs_i == '0) ? '0 :
                      (wrEn && wb_i.dest == rs_i) ? wb_i.result : regs[rs_i];
    assign rtData_o = (rt_i == '0) ? '0 :
                      (wrEn && wb_i.dest == rt_i) ? wb_i.result : regs[rt_i];

endmodule

// File: rtl/fetchStage.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module fetchStage (
    input  logic                clk_i,
    input  logic                rstN_i,
    input  mips_pkg::redirect_t redirect_i,
    input  mips_pkg::word_t     instr_i,
    output mips_pkg::word_t     instAddr_o,
    output mips_pkg::word_t     fetchPc_o,
    output mips_pkg::word_t     fetchInstr_o,
    output logic                fetchValid_o
);

    mips_pkg::word_t pcQ;
    mips_pkg::word_t pcNext;

    assign instAddr_o = pcQ;
    assign pcNext     = redirect_i.taken ? redirect_i.target : pcQ + 32'd4;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            pcQ <= `MIPS_RESET_PC;
        end else begin
            pcQ <= pcNext;
        end
    end

    // fetch/decode register; word fetched under a taken branch becomes a bubble
    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            fetchValid_o <= 1'b0;
        end else begin
            fetchValid_o <= ~redirect_i.taken;
        end
        fetchPc_o    <= pcQ;
        fetchInstr_o <= instr_i;
    end

endmodule

// File: rtl/mips_pkg.sv
`include "mips_params.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0]     word_t;
    typedef logic [`MIPS_REG_BITS-1:0] regNum_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI  // passes operand b through
    } aluOp_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branchKind_t;

    typedef enum logic [1:0] {
        FWD_REG,  // value read in decode
        FWD_MEM,
        FWD_WB
    } fwdSrc_t;

    typedef struct packed {
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
        logic        aluSrcImm;  // operand b from immediate
        aluOp_t      aluOp;
        branchKind_t branchKind;
    } ctrl_t;

    typedef struct packed {
        logic    valid;
        word_t   pc;
        ctrl_t   ctrl;
        regNum_t rs;
        regNum_t rt;
        regNum_t dest;
        word_t   rsVal;
        word_t   rtVal;
        word_t   imm;
        word_t   brTarget;
    } idEx_t;

    typedef struct packed {
        logic    valid;
        word_t   pc;
        ctrl_t   ctrl;
        regNum_t dest;
        word_t   aluResult;
        word_t   storeData;  // forwarded rt
    } exMem_t;

    typedef struct packed {
        logic    valid;
        word_t   pc;
        logic    regWrite;
        regNum_t dest;
        word_t   result;
    } memWb_t;

    typedef struct packed {
        word_t      pc;
        logic [3:0] wen;
        regNum_t    wnum;
        word_t      wdata;
    } debugWb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

// File: rtl/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

`define MIPS_XLEN      32
`define MIPS_REG_BITS  5
`define MIPS_REG_COUNT 32
`define MIPS_RESET_PC  32'hBFC0_0000

// primary opcodes, instr[31:26]
`define MIPS_OP_RTYPE  6'h00
`define MIPS_OP_BEQ    6'h04
`define MIPS_OP_BNE    6'h05
`define MIPS_OP_ADDIU  6'h09
`define MIPS_OP_LUI    6'h0F
`define MIPS_OP_LW     6'h23
`define MIPS_OP_SW     6'h2B

// R-type funct, instr[5:0]
`define MIPS_FN_ADDU   6'h21
`define MIPS_FN_SUBU   6'h23
`define MIPS_FN_AND    6'h24
`define MIPS_FN_OR     6'h25
`define MIPS_FN_SLT    6'h2A

`endif
